// File: Bender.yml
package:
  name: duck_hunt

sources:
  - files:
      - hw/duckHuntPkg.sv
      - hw/flightIf.sv
      - hw/scoreIf.sv
      - hw/gameSequencer.sv
      - hw/duckFlight.sv
      - hw/scoreKeeper.sv
      - hw/duckHuntTop.sv
  - target: test
    files:
      - verification/duckHunt_chk.sv
      - verification/duckHuntTb.sv

// File: hw/duckFlight.sv
`timescale 1ns/10ps
`default_nettype none

module duckFlight (
	input wire ANIM_Clk,
	input wire Reset,
	input wire duckHuntPkg::colorT ColorRand,
	input wire duckHuntPkg::directionT DirectionRand,
	input wire [1:0] RepeatRand,
	input wire duckHuntPkg::coordT StartXRand,
	flightIf.flight FlightBus
);

	duckHuntPkg::coordT duckX;
	duckHuntPkg::coordT duckY;
	duckHuntPkg::colorT color;
	duckHuntPkg::directionT direction;
	duckHuntPkg::directionT newDirection;
	duckHuntPkg::directionT bounceDirection;
	duckHuntPkg::coordT stepX;
	duckHuntPkg::coordT stepY;
	logic [2:0] repeatCount;
	logic [2:0] repeatLimit;
	logic westward;
	logic rising;
	logic flat;
	logic hitX;
	logic hitY;

	function automatic duckHuntPkg::directionT mirrorX(input duckHuntPkg::directionT dir);
		case (dir)
			duckHuntPkg::DirNW: return duckHuntPkg::DirNE;
			duckHuntPkg::DirNE: return duckHuntPkg::DirNW;
			duckHuntPkg::DirW: return duckHuntPkg::DirE;
			duckHuntPkg::DirE: return duckHuntPkg::DirW;
			duckHuntPkg::DirSW: return duckHuntPkg::DirSE;
			default: return duckHuntPkg::DirSW;
		endcase
	endfunction

	function automatic duckHuntPkg::directionT mirrorY(input duckHuntPkg::directionT dir);
		case (dir)
			duckHuntPkg::DirNW: return duckHuntPkg::DirSW;
			duckHuntPkg::DirW: return duckHuntPkg::DirSW;
			duckHuntPkg::DirNE: return duckHuntPkg::DirSE;
			duckHuntPkg::DirE: return duckHuntPkg::DirSE;
			duckHuntPkg::DirSW: return duckHuntPkg::DirNW;
			default: return duckHuntPkg::DirNE;
		endcase
	endfunction

	// Codes 6 and 7 fold onto NW and W
	assign newDirection = (DirectionRand > duckHuntPkg::DirSE) ? DirectionRand - 3'd6
		: DirectionRand;

	////////////////////////////////////////////////////////////
	// Step table and edge detection
	////////////////////////////////////////////////////////////
	assign westward = direction inside {duckHuntPkg::DirNW, duckHuntPkg::DirW, duckHuntPkg::DirSW};
	assign rising = direction inside {duckHuntPkg::DirNW, duckHuntPkg::DirW,
		duckHuntPkg::DirNE, duckHuntPkg::DirE};
	assign flat = (direction == duckHuntPkg::DirW) || (direction == duckHuntPkg::DirE);

	always_comb
	begin
		stepX = flat ? duckHuntPkg::StepLargeX : duckHuntPkg::StepSmallX;
		stepY = flat ? duckHuntPkg::StepSmallY : duckHuntPkg::StepLargeY;
		if (westward)
			stepX = -stepX;
		if (rising)
			stepY = -stepY;	// Screen Y grows downward
	end

	assign hitX = westward ? (duckX <= 0) : (duckX >= duckHuntPkg::FieldMaxX);
	assign hitY = rising ? (duckY <= 0) : (duckY >= duckHuntPkg::FieldFloorY);

	always_comb
	begin
		bounceDirection = direction;
		if (hitX)
			bounceDirection = mirrorX(bounceDirection);
		if (hitY)
			bounceDirection = mirrorY(bounceDirection);	// Corners mirror both
	end

	always_ff @(posedge ANIM_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			direction <= duckHuntPkg::DirNW;
			repeatCount <= '0;
			repeatLimit <= 3'd3;
		end
		else if (FlightBus.Launch)
		begin
			direction <= newDirection;
			repeatCount <= '0;
			repeatLimit <= {1'b0, RepeatRand} + 3'd3;
		end
		else if (FlightBus.Fly)
		begin
			if (hitX || hitY)
			begin
				direction <= bounceDirection;
				repeatCount <= '0;
			end
			else if (repeatCount == repeatLimit - 3'd1)
			begin
				direction <= newDirection;	// Random turn
				repeatCount <= '0;
				repeatLimit <= {1'b0, RepeatRand} + 3'd3;
			end
			else
				repeatCount <= repeatCount + 3'd1;
		end
	end

	always_ff @(posedge ANIM_Clk)
	begin
		if (FlightBus.Launch)
		begin
			color <= (ColorRand > duckHuntPkg::ColorPink) ? duckHuntPkg::ColorBlack : ColorRand;
			duckX <= StartXRand;
			duckY <= duckHuntPkg::LaunchY;
		end
		else if (FlightBus.Fly)
		begin
			if (hitX || hitY)
			begin
				if (hitX)
					duckX <= westward ? duckHuntPkg::BounceInset
						: duckHuntPkg::FieldMaxX - duckHuntPkg::BounceInset;
				if (hitY)
					duckY <= rising ? duckHuntPkg::BounceInset
						: duckHuntPkg::FieldFloorY - duckHuntPkg::BounceInset;
			end
			else
			begin
				duckX <= duckX + stepX;
				duckY <= duckY + stepY;
			end
		end
		else if (FlightBus.Fall)
			duckY <= duckY + duckHuntPkg::FallStep;
	end

	assign FlightBus.DuckX = duckX;
	assign FlightBus.DuckY = duckY;
	assign FlightBus.Color = color;
	assign FlightBus.Landed = (duckY > duckHuntPkg::FallEndY);

endmodule

`default_nettype wire

// File: hw/duckHuntPkg.sv
`default_nettype none

package duckHuntPkg;

	////////////////////////////////////////////////////////////
	// Vector types
	////////////////////////////////////////////////////////////
	typedef logic signed [10:0] coordT;	// Pixel position
	typedef logic [20:0] scoreT;
	typedef logic [7:0] roundT;	// Starts at 1
	typedef logic [1:0] colorT;
	typedef logic [2:0] directionT;
	typedef logic [3:0] duckCountT;

	localparam colorT ColorBlack = 2'd0;
	localparam colorT ColorPink = 2'd2;	// Highest valid colour

	localparam directionT DirNW = 3'd0;
	localparam directionT DirW = 3'd1;
	localparam directionT DirNE = 3'd2;
	localparam directionT DirE = 3'd3;
	localparam directionT DirSW = 3'd4;
	localparam directionT DirSE = 3'd5;

	////////////////////////////////////////////////////////////
	// Field geometry and motion
	////////////////////////////////////////////////////////////
	localparam coordT FieldMaxX = 11'sd576;
	localparam coordT FieldFloorY = 11'sd236;
	localparam coordT BounceInset = 11'sd20;
	localparam coordT LaunchY = 11'sd236;
	localparam coordT FallStep = 11'sd10;
	localparam coordT FallEndY = 11'sd300;

	localparam coordT StepLargeX = 11'sd15;
	localparam coordT StepSmallX = 11'sd12;
	localparam coordT StepLargeY = 11'sd10;
	localparam coordT StepSmallY = 11'sd2;

	// Frame counts
	localparam int FlyAwayFrames = 60;
	localparam int FlyAwayWarnFrames = 50;
	localparam int ShotsPerDuck = 3;
	localparam int DucksPerRound = 10;
	localparam int HitHoldFrames = 15;
	localparam int DogShowFrames = 15;	// Stands in for the dog show
	localparam int EndRoundFrames = 10;

	////////////////////////////////////////////////////////////
	// Scoring and round rules
	////////////////////////////////////////////////////////////
	localparam roundT ScoreTierRound [2] = '{8'd6, 8'd11};	// First round of tiers 1 and 2
	localparam scoreT PointTable [3][3] = '{
		'{21'd500, 21'd800, 21'd1000},	// Black
		'{21'd1500, 21'd2400, 21'd3000},	// Red
		'{21'd1000, 21'd1600, 21'd2000}	// Pink
	};

	localparam roundT KillBoundRound [4] = '{8'd11, 8'd13, 8'd15, 8'd20};
	localparam duckCountT KillsNeeded [5] = '{4'd6, 4'd7, 4'd8, 4'd9, 4'd10};

endpackage

`default_nettype wire

// File: hw/duckHuntTop.sv
`timescale 1ns/10ps
`default_nettype none

module duckHuntTop (
	input wire ANIM_Clk,
	input wire Reset,
	input wire StartGame,
	input wire ShotValid,
	input wire ShotHit,
	input wire duckHuntPkg::colorT ColorRand,
	input wire duckHuntPkg::directionT DirectionRand,
	input wire [1:0] RepeatRand,
	input wire duckHuntPkg::coordT StartXRand,
	output logic ShotReady,
	output duckHuntPkg::coordT DuckX,
	output duckHuntPkg::coordT DuckY,
	output duckHuntPkg::colorT DuckColor,
	output logic DuckActive,
	output logic FlyAway,
	output duckHuntPkg::scoreT Score,
	output duckHuntPkg::scoreT HighScore,
	output duckHuntPkg::roundT RoundNumber,
	output duckHuntPkg::duckCountT DuckNumber,
	output duckHuntPkg::duckCountT KillCount,
	output logic GameOver
);

	flightIf flightBus();
	scoreIf scoreBus();

	gameSequencer sequencer_inst (
		.ANIM_Clk(ANIM_Clk),
		.Reset(Reset),
		.StartGame(StartGame),
		.ShotValid(ShotValid),
		.ShotHit(ShotHit),
		.ShotReady(ShotReady),
		.FlightBus(flightBus.sequencer),
		.ScoreBus(scoreBus.sequencer),
		.DuckActive(DuckActive),
		.FlyAway(FlyAway),
		.RoundNumber(RoundNumber),
		.DuckNumber(DuckNumber),
		.KillCount(KillCount),
		.GameOver(GameOver)
	);

	duckFlight flight_inst (
		.ANIM_Clk(ANIM_Clk),
		.Reset(Reset),
		.ColorRand(ColorRand),
		.DirectionRand(DirectionRand),
		.RepeatRand(RepeatRand),
		.StartXRand(StartXRand),
		.FlightBus(flightBus.flight)
	);

	scoreKeeper keeper_inst (
		.ANIM_Clk(ANIM_Clk),
		.Reset(Reset),
		.ScoreBus(scoreBus.keeper),
		.HighScore(HighScore)
	);

	assign DuckX = flightBus.DuckX;
	assign DuckY = flightBus.DuckY;
	assign DuckColor = flightBus.Color;
	assign Score = scoreBus.Score;

endmodule

`default_nettype wire

// File: hw/flightIf.sv
`timescale 1ns/10ps
`default_nettype none

interface flightIf;
	logic Launch;	// One frame per new duck
	logic Fly;
	logic Fall;
	duckHuntPkg::coordT DuckX;
	duckHuntPkg::coordT DuckY;
	duckHuntPkg::colorT Color;
	logic Landed;

	modport sequencer (
		output Launch,
		output Fly,
		output Fall,
		input Color,
		input Landed
	);

	modport flight (
		input Launch,
		input Fly,
		input Fall,
		output DuckX,
		output DuckY,
		output Color,
		output Landed
	);
endinterface

`default_nettype wire

// File: hw/gameSequencer.sv
`timescale 1ns/10ps
`default_nettype none

module gameSequencer (
	input wire ANIM_Clk,
	input wire Reset,
	input wire StartGame,
	input wire ShotValid,
	input wire ShotHit,
	output logic ShotReady,
	flightIf.sequencer FlightBus,
	scoreIf.sequencer ScoreBus,
	output logic DuckActive,
	output logic FlyAway,
	output duckHuntPkg::roundT RoundNumber,
	output duckHuntPkg::duckCountT DuckNumber,
	output duckHuntPkg::duckCountT KillCount,
	output logic GameOver
);

	typedef enum logic [3:0] {
		MainMenu,
		Launch,
		Flying,
		HitHold,
		Falling,
		DogShow,
		EndRound,
		GameOverWait,
		NewRound
	} stateT;

	stateT state;
	stateT nextState;
	logic [4:0] pauseCount;	// Shared by all timed states
	logic [5:0] flyTimer;
	logic [1:0] shotCount;	// Misses of the current duck
	logic shotAccept;
	logic creditPulse;
	logic clearPulse;
	logic commitPulse;

	function automatic duckHuntPkg::duckCountT killsNeeded(input duckHuntPkg::roundT round);
		duckHuntPkg::duckCountT needed;
		needed = duckHuntPkg::KillsNeeded[0];
		for (int i = 0; i < 4; i++)
		begin
			if (round >= duckHuntPkg::KillBoundRound[i])
				needed = duckHuntPkg::KillsNeeded[i + 1];
		end
		return needed;
	endfunction

	assign ShotReady = (state == Flying) && (shotCount < 2'(duckHuntPkg::ShotsPerDuck));
	assign shotAccept = ShotValid && ShotReady;
	assign DuckActive = (state == Flying);
	assign FlyAway = (state == Flying) && (flyTimer >= 6'(duckHuntPkg::FlyAwayWarnFrames));

	assign FlightBus.Launch = (state == Launch);
	assign FlightBus.Fly = (state == Flying);
	assign FlightBus.Fall = (state == Falling);

	assign ScoreBus.Credit = creditPulse;
	assign ScoreBus.Color = FlightBus.Color;
	assign ScoreBus.Round = RoundNumber;
	assign ScoreBus.ClearScore = clearPulse;
	assign ScoreBus.CommitHigh = commitPulse;

	////////////////////////////////////////////////////////////
	// Round flow
	////////////////////////////////////////////////////////////
	always_comb
	begin
		nextState = state;
		case (state)
			MainMenu:
				if (StartGame)
					nextState = Launch;
			Launch:
				nextState = Flying;
			Flying:
				if (shotAccept && ShotHit)
					nextState = HitHold;
				else if (shotAccept && (shotCount == 2'(duckHuntPkg::ShotsPerDuck - 1)))
					nextState = DogShow;	// Out of shots
				else if (flyTimer == 6'(duckHuntPkg::FlyAwayFrames - 1))
					nextState = DogShow;
			HitHold:
				if (pauseCount == 5'(duckHuntPkg::HitHoldFrames - 1))
					nextState = Falling;
			Falling:
				if (FlightBus.Landed)
					nextState = DogShow;
			DogShow:
				if (pauseCount == 5'(duckHuntPkg::DogShowFrames - 1))
				begin
					if (DuckNumber == duckHuntPkg::duckCountT'(duckHuntPkg::DucksPerRound))
						nextState = EndRound;
					else
						nextState = Launch;
				end
			EndRound:
				if (pauseCount == 5'(duckHuntPkg::EndRoundFrames - 1))
				begin
					if (KillCount < killsNeeded(RoundNumber))
						nextState = GameOverWait;
					else
						nextState = NewRound;
				end
			GameOverWait:
				if (pauseCount == 5'(duckHuntPkg::EndRoundFrames - 1))
					nextState = MainMenu;
			NewRound:
				nextState = Launch;
			default:
				nextState = MainMenu;
		endcase
	end

	always_ff @(posedge ANIM_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			state <= MainMenu;
			pauseCount <= '0;
			flyTimer <= '0;
			shotCount <= '0;
			RoundNumber <= 8'd1;
			DuckNumber <= '0;
			KillCount <= '0;
			GameOver <= 1'b0;
			creditPulse <= 1'b0;
			clearPulse <= 1'b0;
			commitPulse <= 1'b0;
		end
		else
		begin
			state <= nextState;
			if (nextState != state)
				pauseCount <= '0;
			else
				pauseCount <= pauseCount + 5'd1;

			creditPulse <= shotAccept && ShotHit;
			clearPulse <= (state == MainMenu) && StartGame;
			commitPulse <= (nextState != state)
				&& ((nextState == EndRound) || (nextState == GameOverWait));

			case (state)
				MainMenu:
					if (StartGame)
					begin
						RoundNumber <= 8'd1;
						DuckNumber <= '0;
						KillCount <= '0;
						GameOver <= 1'b0;
					end
				Launch:
				begin
					flyTimer <= '0;
					shotCount <= '0;
					DuckNumber <= DuckNumber + 4'd1;
				end
				Flying:
				begin
					flyTimer <= flyTimer + 6'd1;
					if (shotAccept)
					begin
						if (ShotHit)
							KillCount <= KillCount + 4'd1;
						else
							shotCount <= shotCount + 2'd1;
					end
				end
				EndRound:
					if (nextState == GameOverWait)
						GameOver <= 1'b1;	// Held until the next start
				NewRound:
				begin
					RoundNumber <= RoundNumber + 8'd1;
					DuckNumber <= '0;
					KillCount <= '0;
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/scoreIf.sv
`timescale 1ns/10ps
`default_nettype none

interface scoreIf;
	logic Credit;	// One frame per kill
	duckHuntPkg::colorT Color;
	duckHuntPkg::roundT Round;
	logic ClearScore;
	logic CommitHigh;
	duckHuntPkg::scoreT Score;

	modport sequencer (
		output Credit,
		output Color,
		output Round,
		output ClearScore,
		output CommitHigh
	);

	modport keeper (
		input Credit,
		input Color,
		input Round,
		input ClearScore,
		input CommitHigh,
		output Score
	);
endinterface

`default_nettype wire

// File: hw/scoreKeeper.sv
`timescale 1ns/10ps
`default_nettype none

module scoreKeeper (
	input wire ANIM_Clk,
	input wire Reset,
	scoreIf.keeper ScoreBus,
	output duckHuntPkg::scoreT HighScore
);

	duckHuntPkg::scoreT score;
	duckHuntPkg::scoreT points;
	duckHuntPkg::colorT colorIndex;
	logic [1:0] tier;

	// Points lookup
	always_comb
	begin
		colorIndex = (ScoreBus.Color > duckHuntPkg::ColorPink) ? duckHuntPkg::ColorBlack
			: ScoreBus.Color;
		if (ScoreBus.Round < duckHuntPkg::ScoreTierRound[0])
			tier = 2'd0;
		else if (ScoreBus.Round < duckHuntPkg::ScoreTierRound[1])
			tier = 2'd1;	// Rounds 6 to 10
		else
			tier = 2'd2;
		points = duckHuntPkg::PointTable[colorIndex][tier];
	end

	always_ff @(posedge ANIM_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			score <= '0;
			HighScore <= '0;
		end
		else
		begin
			if (ScoreBus.ClearScore)
				score <= '0;
			else if (ScoreBus.Credit)
				score <= score + points;

			// High score survives a new game
			if (ScoreBus.CommitHigh && (score > HighScore))
				HighScore <= score;
		end
	end

	assign ScoreBus.Score = score;

endmodule

`default_nettype wire

// File: verification/duckHuntTb.sv
`timescale 1ns/10ps
`default_nettype none

module duckHuntTb;

	typedef enum {DuckHit, DuckMissed, DuckUnshot} duckActionT;

	logic ANIM_Clk;
	logic Reset;
	logic StartGame;
	logic ShotValid;
	logic ShotHit;
	duckHuntPkg::colorT ColorRand;
	duckHuntPkg::directionT DirectionRand;
	logic [1:0] RepeatRand;
	duckHuntPkg::coordT StartXRand;
	logic ShotReady;
	duckHuntPkg::coordT DuckX;
	duckHuntPkg::coordT DuckY;
	duckHuntPkg::colorT DuckColor;
	logic DuckActive;
	logic FlyAway;
	duckHuntPkg::scoreT Score;
	duckHuntPkg::scoreT HighScore;
	duckHuntPkg::roundT RoundNumber;
	duckHuntPkg::duckCountT DuckNumber;
	duckHuntPkg::duckCountT KillCount;
	logic GameOver;

	logic [31:0] inputSeed = 32'd13;
	logic [31:0] choiceSeed = 32'd13;
	duckHuntPkg::scoreT expectedScore = '0;	// Owned by the monitor between games
	duckHuntPkg::scoreT expectedHigh = '0;
	duckHuntPkg::duckCountT expectedKills = '0;
	duckHuntPkg::roundT expectedRound = 8'd1;
	duckHuntPkg::colorT expectedColor = '0;
	duckHuntPkg::colorT launchColor = '0;
	duckHuntPkg::coordT launchX = '0;
	logic wasActive = 1'b0;
	int checkDelay = 0;
	int acceptedShots = 0;
	logic flyAwaySeen = 1'b0;

	duckHuntTop duckHuntTop_inst (.*);

	initial
	begin
		ANIM_Clk = 1'b0;
		forever
			#4 ANIM_Clk = ~ANIM_Clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////
	function automatic duckHuntPkg::scoreT pointsFor(input duckHuntPkg::colorT color,
		input duckHuntPkg::roundT round);
		int tier;
		tier = (round <= 5) ? 0 : ((round <= 10) ? 1 : 2);
		case (color)
			2'd1: return duckHuntPkg::scoreT'((tier == 0) ? 1500 : ((tier == 1) ? 2400 : 3000));
			2'd2: return duckHuntPkg::scoreT'((tier == 0) ? 1000 : ((tier == 1) ? 1600 : 2000));
			default: return duckHuntPkg::scoreT'((tier == 0) ? 500 : ((tier == 1) ? 800 : 1000));
		endcase
	endfunction

	function automatic duckHuntPkg::duckCountT killsToPass(input duckHuntPkg::roundT round);
		if (round >= 20)
			return 4'd10;
		else if (round >= 15)
			return 4'd9;
		else if (round >= 13)
			return 4'd8;
		else if (round >= 11)
			return 4'd7;
		return 4'd6;
	endfunction

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////
	task automatic stopRun();
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic raiseTimeout(input string what);
		$display("Timed out at %0t while waiting for %s", $time, what);
		stopRun();
	endtask

	task automatic checkScore(input string name, input duckHuntPkg::scoreT got,
		input duckHuntPkg::scoreT expected);
		if (got !== expected)
		begin
			$display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, expected);
			stopRun();
		end
	endtask

	task automatic checkRound(input string name, input duckHuntPkg::roundT got,
		input duckHuntPkg::roundT expected);
		if (got !== expected)
		begin
			$display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, expected);
			stopRun();
		end
	endtask

	task automatic checkCount(input string name, input duckHuntPkg::duckCountT got,
		input duckHuntPkg::duckCountT expected);
		if (got !== expected)
		begin
			$display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, expected);
			stopRun();
		end
	endtask

	task automatic checkColor(input string name, input duckHuntPkg::colorT got,
		input duckHuntPkg::colorT expected);
		if (got !== expected)
		begin
			$display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, expected);
			stopRun();
		end
	endtask

	task automatic checkCoordRange(input string name, input duckHuntPkg::coordT got,
		input duckHuntPkg::coordT low, input duckHuntPkg::coordT high);
		if ($isunknown(got) || (got < low) || (got > high))
		begin
			$display("[FAIL] %0t %s got %0d expected %0d to %0d", $time, name, got, low, high);
			stopRun();
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic expected);
		if (got !== expected)
		begin
			$display("[FAIL] %0t %s got %b expected %b", $time, name, got, expected);
			stopRun();
		end
	endtask

	////////////////////////////////////////////////////////////
	// Random inputs and monitor
	////////////////////////////////////////////////////////////
	initial
	begin
		ColorRand = '0;
		DirectionRand = '0;
		RepeatRand = '0;
		StartXRand = '0;
		forever
		begin
			@(posedge ANIM_Clk);
			inputSeed = xorshift32(inputSeed);
			ColorRand <= inputSeed[1:0];
			DirectionRand <= inputSeed[4:2];
			RepeatRand <= inputSeed[6:5];
			StartXRand <= duckHuntPkg::coordT'(inputSeed[31:16] % 577);	// Inside the field
		end
	end

	always @(negedge ANIM_Clk)
	begin
		if (!Reset)
		begin
			if (duckHuntTop_inst.checker_inst.failCount != 0)
			begin
				$display("A concurrent assertion in the bound checker failed");
				stopRun();
			end
			if (DuckActive && !wasActive)	// First frame of a new duck
			begin
				expectedColor = (launchColor == 2'd3) ? 2'd0 : launchColor;
				checkColor("DuckColor", DuckColor, expectedColor);
				checkCoordRange("DuckX", DuckX, launchX, launchX);
				checkCoordRange("DuckY", DuckY, duckHuntPkg::LaunchY, duckHuntPkg::LaunchY);
			end
			if (DuckActive)
			begin
				checkCoordRange("DuckX", DuckX, -duckHuntPkg::StepLargeX,
					duckHuntPkg::FieldMaxX + duckHuntPkg::StepLargeX);
				checkCoordRange("DuckY", DuckY, -duckHuntPkg::StepLargeY,
					duckHuntPkg::FieldFloorY + duckHuntPkg::StepLargeY);
				if (FlyAway)
					flyAwaySeen = 1'b1;
			end
			if (checkDelay > 0)
			begin
				checkDelay--;
				if (checkDelay == 0)
				begin
					checkScore("Score", Score, expectedScore);
					checkCount("KillCount", KillCount, expectedKills);
				end
			end
			if (ShotValid && ShotReady)	// Taken on the coming edge
			begin
				acceptedShots++;
				if (ShotHit)
				begin
					expectedKills = expectedKills + 4'd1;
					expectedScore += pointsFor(expectedColor, expectedRound);
				end
				checkDelay = 2;
			end
		end
		wasActive = DuckActive;
		launchColor = ColorRand;	// Latched by a launch on the coming edge
		launchX = StartXRand;
	end

	////////////////////////////////////////////////////////////
	// Game actions
	////////////////////////////////////////////////////////////
	task automatic waitActive(input logic level, input int limit, input string what);
		int waited;
		waited = 0;
		do
		begin
			@(negedge ANIM_Clk);
			waited++;
			if (waited > limit)
				raiseTimeout(what);
		end
		while (DuckActive !== level);
	endtask

	task automatic startGame();
		int waited;
		waited = 0;
		@(posedge ANIM_Clk);
		StartGame <= 1'b1;
		do
		begin
			@(negedge ANIM_Clk);
			waited++;
			if (waited > 40)
				raiseTimeout("the first duck after StartGame");
		end
		while (DuckActive !== 1'b1);
		@(posedge ANIM_Clk);
		StartGame <= 1'b0;
	endtask

	task automatic fireShot(input logic hit);
		int waited;
		waited = 0;
		@(posedge ANIM_Clk);
		ShotValid <= 1'b1;
		ShotHit <= hit;
		do
		begin
			@(negedge ANIM_Clk);
			waited++;
			if (waited > 80)
				raiseTimeout("ShotReady");
		end
		while (ShotReady !== 1'b1);
		@(posedge ANIM_Clk);
		ShotValid <= 1'b0;
		ShotHit <= 1'b0;
	endtask

	task automatic playDuck(input duckActionT action, input duckHuntPkg::duckCountT index,
		input duckHuntPkg::roundT round);
		int shotsBefore;
		waitActive(1'b1, 150, "a duck launch");
		checkCount("DuckNumber", DuckNumber, index);
		checkRound("RoundNumber", RoundNumber, round);
		case (action)
			DuckHit:
			begin
				fireShot(1'b1);
				waitActive(1'b0, 80, "the end of a hit duck");
			end
			DuckMissed:
			begin
				shotsBefore = acceptedShots;
				@(posedge ANIM_Clk);
				ShotValid <= 1'b1;	// Held on through the back-pressure
				ShotHit <= 1'b0;
				waitActive(1'b0, 80, "the end of a missed duck");
				repeat (5) @(negedge ANIM_Clk);
				if (acceptedShots != shotsBefore + duckHuntPkg::ShotsPerDuck)
				begin
					$display("Counted %0d shots for one duck instead of three",
						acceptedShots - shotsBefore);
					stopRun();
				end
				checkScore("Score", Score, expectedScore);
				@(posedge ANIM_Clk);
				ShotValid <= 1'b0;
			end
			default:
			begin
				flyAwaySeen = 1'b0;
				waitActive(1'b0, 80, "a duck to fly away");
				if (!flyAwaySeen)
				begin
					$display("The duck flew away without FlyAway going high");
					stopRun();
				end
			end
		endcase
	endtask

	task automatic finishRound();
		int waited;
		waited = 0;
		do
		begin
			@(negedge ANIM_Clk);
			waited++;
			if (waited > 120)
				raiseTimeout("the round decision");
		end
		while (!GameOver && (RoundNumber == expectedRound));
		if (expectedScore > expectedHigh)
			expectedHigh = expectedScore;
		checkScore("HighScore", HighScore, expectedHigh);
		if (expectedKills >= killsToPass(expectedRound))
		begin
			expectedRound = expectedRound + 8'd1;
			expectedKills = '0;
			checkRound("RoundNumber", RoundNumber, expectedRound);
			checkBit("GameOver", GameOver, 1'b0);
			checkCount("KillCount", KillCount, expectedKills);
		end
		else
		begin
			checkBit("GameOver", GameOver, 1'b1);
			checkRound("RoundNumber", RoundNumber, expectedRound);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Scenario
	////////////////////////////////////////////////////////////
	initial
	begin
		int duckIndex;
		duckActionT action;
		StartGame = 1'b0;
		ShotValid = 1'b0;
		ShotHit = 1'b0;
		Reset = 1'b1;
		repeat (16) @(posedge ANIM_Clk);
		Reset <= 1'b0;
		@(negedge ANIM_Clk);
		checkScore("Score", Score, '0);
		checkScore("HighScore", HighScore, '0);
		checkRound("RoundNumber", RoundNumber, 8'd1);
		checkCount("KillCount", KillCount, '0);
		checkBit("GameOver", GameOver, 1'b0);
		checkBit("FlyAway", FlyAway, 1'b0);
		repeat (20)
		begin
			@(negedge ANIM_Clk);
			checkBit("DuckActive", DuckActive, 1'b0);	// No launch from the menu
			checkBit("ShotReady", ShotReady, 1'b0);
			checkCount("DuckNumber", DuckNumber, '0);
		end

		// Round 1 passes with eight kills
		startGame();
		playDuck(DuckUnshot, 4'd1, 8'd1);
		playDuck(DuckMissed, 4'd2, 8'd1);
		for (duckIndex = 3; duckIndex <= 10; duckIndex++)
			playDuck(DuckHit, duckHuntPkg::duckCountT'(duckIndex), 8'd1);
		finishRound();

		// Round 2 ends the game with three kills
		for (duckIndex = 1; duckIndex <= 10; duckIndex++)
		begin
			choiceSeed = xorshift32(choiceSeed);
			if (duckIndex <= 3)
				action = DuckHit;
			else if (choiceSeed[0])
				action = DuckMissed;
			else
				action = DuckUnshot;
			playDuck(action, duckHuntPkg::duckCountT'(duckIndex), 8'd2);
		end
		finishRound();

		repeat (20)
		begin
			@(negedge ANIM_Clk);
			checkBit("GameOver", GameOver, 1'b1);
			checkBit("DuckActive", DuckActive, 1'b0);
		end
		expectedScore = '0;
		expectedKills = '0;
		expectedRound = 8'd1;
		startGame();
		@(negedge ANIM_Clk);
		checkBit("GameOver", GameOver, 1'b0);
		checkScore("Score", Score, '0);
		checkScore("HighScore", HighScore, expectedHigh);
		playDuck(DuckHit, 4'd1, 8'd1);
		repeat (4) @(negedge ANIM_Clk);
		if (duckHuntTop_inst.checker_inst.failCount != 0)
		begin
			$display("A concurrent assertion in the bound checker failed");
			stopRun();
		end
		else
		begin
			$display("NO ERRORS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: verification/duckHunt_chk.sv
`timescale 1ns/10ps
`default_nettype none

module duckHunt_chk (
	input wire ANIM_Clk,
	input wire Reset,
	input wire ShotReady,
	input wire DuckActive,
	input wire GameOver,
	input wire duckHuntPkg::scoreT Score,
	input wire ClearScore
);

	int failCount = 0;	// Polled by the testbench monitor

	readyInFlight: assert property (@(posedge ANIM_Clk) disable iff (Reset)
		ShotReady |-> DuckActive)
	else
	begin
		$error("ShotReady high while no duck flies");
		failCount++;
	end

	// Score only drops when a new game clears it
	scoreMonotonic: assert property (@(posedge ANIM_Clk) disable iff (Reset)
		(Score < $past(Score)) |-> $past(ClearScore))
	else
	begin
		$error("Score decreased outside a game start");
		failCount++;
	end

	noFlightAfterGameOver: assert property (@(posedge ANIM_Clk) disable iff (Reset)
		!(GameOver && DuckActive))
	else
	begin
		$error("GameOver and DuckActive high together");
		failCount++;
	end

endmodule

bind duckHuntTop duckHunt_chk checker_inst (
	.ANIM_Clk(ANIM_Clk),
	.Reset(Reset),
	.ShotReady(ShotReady),
	.DuckActive(DuckActive),
	.GameOver(GameOver),
	.Score(Score),
	.ClearScore(scoreBus.ClearScore)
);

`default_nettype wire

// File: verilog.f
hw/duckHuntPkg.sv
hw/flightIf.sv
hw/scoreIf.sv
hw/gameSequencer.sv
hw/duckFlight.sv
hw/scoreKeeper.sv
hw/duckHuntTop.sv
verification/duckHunt_chk.sv
verification/duckHuntTb.sv
